/* verif/addr_xlate_stim.txt */
# W offset data | R offset expected_data | L name s0_addr s1_addr then per port paddr mat miss
# C is a lookup like L, issued in the cycle right after the previous one
L reset_mode0 12345678 9abcdef0 00000000 0 0 00000000 0 0
W 04 000002a5
R 04 000002a5
W 1c deadbeef
R 1c 00000000
W 00 00000001
R 00 00000001
L direct 12345678 9abcdef0 12345678 0 0 9abcdef0 0 0
W 00 00000002
W 08 80000011
W 0c a2000021
R 0c a2000021
L dmw_windows 8abc1234 b0001000 0abc1234 1 0 30001000 2 0
W 0c 86000031
L dmw_priority 9fff0000 80000004 1fff0000 1 0 00000004 1 0
W 10 401232a5
W 14 55aa5011
W 18 00000000
W 10 44c00111
W 14 00123063
W 18 00000001
W 10 40200111
W 14 77777031
W 18 00000002
W 10 401232a5
W 14 66666031
W 18 00000003
R 18 00000003
R 14 66666031
L tlb_4k_4m 40123abc 44d56789 55aa5abc 1 0 48d56789 2 0
L asid_miss 40200010 40123004 00000000 0 1 55aa5004 1 0
W 04 00000111
L asid_global 40200010 44c00000 77777010 3 0 48c00000 2 0
W 14 00000000
W 18 00000002
L invalidated 40200010 00001000 00000000 0 1 00000000 0 1
L b2b_a 44c00004 8000beef 48c00004 2 0 0000beef 1 0
C b2b_b 40123000 44ffffff 00000000 0 1 48ffffff 2 0
C b2b_c 9fff0000 00002000 1fff0000 1 0 00000000 0 1

/* flist.f */
source/mmu_pkg.sv
source/tlb_csr_wb.sv
source/tlb_entry.sv
source/tlb_hit_select.sv
source/dmw_match.sv
source/paddr_out.sv
source/addr_xlate_top.sv
verif/addr_xlate_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the address translation testbench, then scan the log
verilator --binary -f flist.f --top-module addr_xlate_tb -o addr_xlate_sim \
    && ./obj_dir/addr_xlate_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log \
    && { echo "Simulation failed"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }

/* verif/addr_xlate_tb.sv */
`timescale 1ns/1ps

module addr_xlate_tb;
    import mmu_pkg::*;

    localparam int    ACK_LIMIT = 16;  // Cycles to wait for a Wishbone acknowledge
    localparam string STIM_FILE = "verif/addr_xlate_stim.txt";

    logic             clk;
    logic             rst_n;
    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_we;
    logic [4:0]       wb_adr;
    logic [31:0]      wb_dat_w;
    logic [31:0]      wb_dat_r;
    logic             wb_ack;
    logic             s0_req;
    logic             s1_req;
    logic [31:0]      s0_addr;
    logic [31:0]      s1_addr;
    logic             s0_vld;
    logic             s1_vld;
    logic [31:0]      s0_paddr;
    logic [31:0]      s1_paddr;
    logic [MAT_W-1:0] s0_mat;
    logic [MAT_W-1:0] s1_mat;
    logic             s0_miss;
    logic             s1_miss;

    int errors;
    int checks;
    int cycles;
    int cycle_limit;

    addr_xlate_top #(.TLB_ENTRIES(8)) addr_xlate_top_i (
        .clk(clk), .rst_n(rst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .s0_req(s0_req), .s1_req(s1_req), .s0_addr(s0_addr), .s1_addr(s1_addr),
        .s0_vld(s0_vld), .s1_vld(s1_vld), .s0_paddr(s0_paddr), .s1_paddr(s1_paddr),
        .s0_mat(s0_mat), .s1_mat(s1_mat), .s0_miss(s0_miss), .s1_miss(s1_miss)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Watchdog on the cycle count, limited by the stimulus length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Error: simulation timed out after %0d cycles", cycles);
            $display("Checks run: %0d, errors: %0d", checks, errors);
            $display("Finished with errors");
            $finish;
        end
    end

    // ************************************************************************
    // Checks
    // ************************************************************************
    task automatic check_data(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_mat(input string name, input logic [MAT_W-1:0] expected,
                             input logic [MAT_W-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // ************************************************************************
    // Bus and lookup drivers
    // ************************************************************************
    task automatic idle_gap();
        repeat ($urandom_range(3, 0)) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wb_access(input logic we, input logic [4:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        int waited;
        waited   = 1;
        rdata    = '0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        @(posedge clk);
        #1;
        while (!wb_ack && waited < ACK_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (wb_ack) begin
            rdata = wb_dat_r;  // Only valid while ack is high
        end else begin
            errors++;
            $display("Error: no Wishbone acknowledge for offset %h", adr);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(posedge clk);
        #1;
    endtask

    // Both ports request together and are checked one cycle later
    task automatic lookup(input string name, input logic [31:0] addr0, input logic [31:0] addr1,
                          input logic [31:0] exp_paddr0, input logic [MAT_W-1:0] exp_mat0,
                          input logic exp_miss0, input logic [31:0] exp_paddr1,
                          input logic [MAT_W-1:0] exp_mat1, input logic exp_miss1);
        s0_req  = 1'b1;
        s1_req  = 1'b1;
        s0_addr = addr0;
        s1_addr = addr1;
        @(posedge clk);
        #1;
        s0_req = 1'b0;
        s1_req = 1'b0;
        check_flag({name, " s0_vld"}, 1'b1, s0_vld);
        check_data({name, " s0_paddr"}, exp_paddr0, s0_paddr);
        check_mat({name, " s0_mat"}, exp_mat0, s0_mat);
        check_flag({name, " s0_miss"}, exp_miss0, s0_miss);
        check_flag({name, " s1_vld"}, 1'b1, s1_vld);
        check_data({name, " s1_paddr"}, exp_paddr1, s1_paddr);
        check_mat({name, " s1_mat"}, exp_mat1, s1_mat);
        check_flag({name, " s1_miss"}, exp_miss1, s1_miss);
    endtask

    task automatic run_stim_file();
        int               fd;
        int               code;
        logic             done;
        string            op;
        string            name;
        string            rest;
        logic [31:0]      off;
        logic [31:0]      data;
        logic [31:0]      rdata;
        logic [31:0]      a0;
        logic [31:0]      a1;
        logic [31:0]      p0;
        logic [31:0]      p1;
        logic [MAT_W-1:0] m0;
        logic [MAT_W-1:0] m1;
        logic             x0;
        logic             x1;
        fd   = $fopen(STIM_FILE, "r");
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, "%s", op);
            if (code != 1) begin
                done = 1'b1;
            end else if (op == "#") begin
                code = $fgets(rest, fd);
            end else if (op == "W") begin
                code = $fscanf(fd, "%h %h", off, data);
                idle_gap();
                wb_access(1'b1, off[4:0], data, rdata);
            end else if (op == "R") begin
                code = $fscanf(fd, "%h %h", off, data);
                idle_gap();
                wb_access(1'b0, off[4:0], 32'h0, rdata);
                check_data($sformatf("read %h", off[4:0]), data, rdata);
            end else if (op == "L" || op == "C") begin
                code = $fscanf(fd, "%s %h %h %h %h %h %h %h %h",
                               name, a0, a1, p0, m0, x0, p1, m1, x1);
                if (op == "L") begin
                    idle_gap();  // C follows the previous lookup without a gap
                end
                lookup(name, a0, a1, p0, m0, x0, p1, m1, x1);
            end else begin
                errors++;
                $display("Error: unknown stimulus operation %s", op);
                code = $fgets(rest, fd);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int    fd;
        int    lines;
        string line;
        errors      = 0;
        checks      = 0;
        lines       = 0;
        rst_n       = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        s0_req      = 1'b0;
        s1_req      = 1'b0;
        s0_addr     = '0;
        s1_addr     = '0;
        void'($urandom(32'h71e47b4a));

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("Error: cannot open stimulus file %s", STIM_FILE);
        end else begin
            while ($fgets(line, fd) != 0) begin
                lines++;
            end
            $fclose(fd);
        end
        cycle_limit = 20 * lines + 100;

        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        if (lines > 0) begin
            run_stim_file();
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* source/addr_xlate_top.sv */
`timescale 1ns/1ps

module addr_xlate_top #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  logic [4:0]                 wb_adr,
    input  logic [31:0]                wb_dat_w,
    output logic [31:0]                wb_dat_r,
    output logic                       wb_ack,
    input  logic                       s0_req,
    input  logic                       s1_req,
    input  logic [31:0]                s0_addr,
    input  logic [31:0]                s1_addr,
    output logic                       s0_vld,
    output logic                       s1_vld,
    output logic [31:0]                s0_paddr,
    output logic [31:0]                s1_paddr,
    output logic [mmu_pkg::MAT_W-1:0]  s0_mat,
    output logic [mmu_pkg::MAT_W-1:0]  s1_mat,
    output logic                       s0_miss,
    output logic                       s1_miss
);
    import mmu_pkg::*;

    xlate_mode_e                 mode;
    logic [ASID_W-1:0]           cur_asid;
    logic [31:0]                 dmw0;
    logic [31:0]                 dmw1;
    logic [TLB_ENTRIES-1:0]      ent_we_vec;
    logic [VPN_W-1:0]            ent_vpn;
    logic [ASID_W-1:0]           ent_asid;
    logic [PFN_W-1:0]            ent_pfn;
    logic [MAT_W-1:0]            ent_mat;
    logic                        ent_g;
    logic                        ent_huge;
    logic                        ent_v;
    logic [TLB_ENTRIES-1:0]      s0_hit_vec;
    logic [TLB_ENTRIES-1:0]      s1_hit_vec;
    logic [TLB_ENTRIES*PFN_W-1:0] pfn_bus;
    logic [TLB_ENTRIES*MAT_W-1:0] mat_bus;
    logic [TLB_ENTRIES-1:0]      huge_bus;
    logic                        s0_tlb_hit;
    logic                        s1_tlb_hit;
    logic [PFN_W-1:0]            s0_pfn;
    logic [PFN_W-1:0]            s1_pfn;
    page_size_e                  s0_ps;
    page_size_e                  s1_ps;
    logic [MAT_W-1:0]            s0_tlb_mat;
    logic [MAT_W-1:0]            s1_tlb_mat;
    logic                        s0_dmw_hit;
    logic                        s1_dmw_hit;
    logic [31:0]                 s0_dmw_paddr;
    logic [31:0]                 s1_dmw_paddr;
    logic [MAT_W-1:0]            s0_dmw_mat;
    logic [MAT_W-1:0]            s1_dmw_mat;

    tlb_csr_wb #(.TLB_ENTRIES(TLB_ENTRIES)) tlb_csr_wb_i (
        .clk(clk), .rst_n(rst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .mode(mode), .cur_asid(cur_asid), .dmw0(dmw0), .dmw1(dmw1),
        .ent_we_vec(ent_we_vec), .ent_vpn(ent_vpn), .ent_asid(ent_asid),
        .ent_pfn(ent_pfn), .ent_mat(ent_mat), .ent_g(ent_g),
        .ent_huge(ent_huge), .ent_v(ent_v)
    );

    // ************************************************************************
    // TLB entries, all sharing the write bus and both lookup addresses
    // ************************************************************************
    for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_entry
        tlb_entry tlb_entry_i (
            .clk(clk), .rst_n(rst_n), .we(ent_we_vec[i]),
            .vpn_in(ent_vpn), .asid_in(ent_asid), .pfn_in(ent_pfn), .mat_in(ent_mat),
            .g_in(ent_g), .huge_in(ent_huge), .v_in(ent_v), .cur_asid(cur_asid),
            .s0_addr(s0_addr), .s1_addr(s1_addr),
            .s0_hit(s0_hit_vec[i]), .s1_hit(s1_hit_vec[i]),
            .pfn(pfn_bus[i*PFN_W +: PFN_W]), .mat(mat_bus[i*MAT_W +: MAT_W]),
            .huge(huge_bus[i])
        );
    end

    tlb_hit_select #(.TLB_ENTRIES(TLB_ENTRIES)) tlb_hit_select_i (
        .s0_hit_vec(s0_hit_vec), .s1_hit_vec(s1_hit_vec),
        .pfn_bus(pfn_bus), .mat_bus(mat_bus), .huge_bus(huge_bus),
        .s0_tlb_hit(s0_tlb_hit), .s1_tlb_hit(s1_tlb_hit),
        .s0_pfn(s0_pfn), .s1_pfn(s1_pfn), .s0_ps(s0_ps), .s1_ps(s1_ps),
        .s0_tlb_mat(s0_tlb_mat), .s1_tlb_mat(s1_tlb_mat)
    );

    dmw_match dmw_match_i (
        .dmw0(dmw0), .dmw1(dmw1), .s0_addr(s0_addr), .s1_addr(s1_addr),
        .s0_dmw_hit(s0_dmw_hit), .s1_dmw_hit(s1_dmw_hit),
        .s0_dmw_paddr(s0_dmw_paddr), .s1_dmw_paddr(s1_dmw_paddr),
        .s0_dmw_mat(s0_dmw_mat), .s1_dmw_mat(s1_dmw_mat)
    );

    paddr_out paddr_out_i (
        .clk(clk), .rst_n(rst_n), .mode(mode),
        .s0_req(s0_req), .s1_req(s1_req), .s0_addr(s0_addr), .s1_addr(s1_addr),
        .s0_dmw_hit(s0_dmw_hit), .s1_dmw_hit(s1_dmw_hit),
        .s0_dmw_paddr(s0_dmw_paddr), .s1_dmw_paddr(s1_dmw_paddr),
        .s0_dmw_mat(s0_dmw_mat), .s1_dmw_mat(s1_dmw_mat),
        .s0_tlb_hit(s0_tlb_hit), .s1_tlb_hit(s1_tlb_hit),
        .s0_pfn(s0_pfn), .s1_pfn(s1_pfn), .s0_ps(s0_ps), .s1_ps(s1_ps),
        .s0_tlb_mat(s0_tlb_mat), .s1_tlb_mat(s1_tlb_mat),
        .s0_vld(s0_vld), .s1_vld(s1_vld), .s0_paddr(s0_paddr), .s1_paddr(s1_paddr),
        .s0_mat(s0_mat), .s1_mat(s1_mat), .s0_miss(s0_miss), .s1_miss(s1_miss)
    );

endmodule

/* source/paddr_out.sv */
`timescale 1ns/1ps

module paddr_out (
    input  logic                       clk,
    input  logic                       rst_n,
    input  mmu_pkg::xlate_mode_e       mode,
    input  logic                       s0_req,
    input  logic                       s1_req,
    input  logic [31:0]                s0_addr,
    input  logic [31:0]                s1_addr,
    input  logic                       s0_dmw_hit,
    input  logic                       s1_dmw_hit,
    input  logic [31:0]                s0_dmw_paddr,
    input  logic [31:0]                s1_dmw_paddr,
    input  logic [mmu_pkg::MAT_W-1:0]  s0_dmw_mat,
    input  logic [mmu_pkg::MAT_W-1:0]  s1_dmw_mat,
    input  logic                       s0_tlb_hit,
    input  logic                       s1_tlb_hit,
    input  logic [mmu_pkg::PFN_W-1:0]  s0_pfn,
    input  logic [mmu_pkg::PFN_W-1:0]  s1_pfn,
    input  mmu_pkg::page_size_e        s0_ps,
    input  mmu_pkg::page_size_e        s1_ps,
    input  logic [mmu_pkg::MAT_W-1:0]  s0_tlb_mat,
    input  logic [mmu_pkg::MAT_W-1:0]  s1_tlb_mat,
    output logic                       s0_vld,
    output logic                       s1_vld,
    output logic [31:0]                s0_paddr,
    output logic [31:0]                s1_paddr,
    output logic [mmu_pkg::MAT_W-1:0]  s0_mat,
    output logic [mmu_pkg::MAT_W-1:0]  s1_mat,
    output logic                       s0_miss,
    output logic                       s1_miss
);
    import mmu_pkg::*;

    logic [MAT_W+32:0] s0_res;
    logic [MAT_W+32:0] s1_res;

    // Result packed as {miss, mat, paddr}. The DMW hit steers both paddr and
    // mat here since the whole translation sits in one register stage
    function automatic logic [MAT_W+32:0] xlate(
        input xlate_mode_e      md,
        input logic [31:0]      addr,
        input logic             dmw_hit,
        input logic [31:0]      dmw_paddr,
        input logic [MAT_W-1:0] dmw_mat,
        input logic             tlb_hit,
        input logic [PFN_W-1:0] pfn,
        input page_size_e       ps,
        input logic [MAT_W-1:0] tlb_mat
    );
        logic [31:0]       tlb_paddr;
        logic [MAT_W+32:0] res;
        case (ps)
            PS_4K:   tlb_paddr = {pfn, addr[11:0]};
            PS_4M:   tlb_paddr = {pfn[9:0], addr[21:0]};
            default: tlb_paddr = '0;
        endcase
        case (md)
            MODE_DIRECT: res = {1'b0, {MAT_W{1'b0}}, addr};
            MODE_MAP: begin
                if (dmw_hit) begin
                    res = {1'b0, dmw_mat, dmw_paddr};
                end else if (tlb_hit) begin
                    res = {1'b0, tlb_mat, tlb_paddr};
                end else begin
                    res = {1'b1, {MAT_W{1'b0}}, 32'h0};  // Nothing maps the address
                end
            end
            default: res = '0;
        endcase
        return res;
    endfunction

    assign s0_res = xlate(mode, s0_addr, s0_dmw_hit, s0_dmw_paddr, s0_dmw_mat,
                          s0_tlb_hit, s0_pfn, s0_ps, s0_tlb_mat);
    assign s1_res = xlate(mode, s1_addr, s1_dmw_hit, s1_dmw_paddr, s1_dmw_mat,
                          s1_tlb_hit, s1_pfn, s1_ps, s1_tlb_mat);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s0_vld <= 1'b0;
            s1_vld <= 1'b0;
        end else begin
            s0_vld <= s0_req;
            s1_vld <= s1_req;
        end
    end

    // Outputs hold their last result while no request is present
    always_ff @(posedge clk) begin
        if (s0_req) begin
            {s0_miss, s0_mat, s0_paddr} <= s0_res;
        end
        if (s1_req) begin
            {s1_miss, s1_mat, s1_paddr} <= s1_res;
        end
    end

endmodule

/* source/dmw_match.sv */
`timescale 1ns/1ps

module dmw_match (
    input  logic [31:0]                dmw0,
    input  logic [31:0]                dmw1,
    input  logic [31:0]                s0_addr,
    input  logic [31:0]                s1_addr,
    output logic                       s0_dmw_hit,
    output logic                       s1_dmw_hit,
    output logic [31:0]                s0_dmw_paddr,
    output logic [31:0]                s1_dmw_paddr,
    output logic [mmu_pkg::MAT_W-1:0]  s0_dmw_mat,
    output logic [mmu_pkg::MAT_W-1:0]  s1_dmw_mat
);
    logic        s0_win0;
    logic        s0_win1;
    logic        s1_win0;
    logic        s1_win1;
    logic [31:0] s0_win;
    logic [31:0] s1_win;

    // Window enabled and its virtual segment equal to the top three address bits
    function automatic logic win_hit(input logic [31:0] dmw, input logic [31:0] addr);
        return dmw[0] && (dmw[31:29] == addr[31:29]);
    endfunction

    assign s0_win0 = win_hit(dmw0, s0_addr);
    assign s0_win1 = win_hit(dmw1, s0_addr);
    assign s1_win0 = win_hit(dmw0, s1_addr);
    assign s1_win1 = win_hit(dmw1, s1_addr);

    assign s0_dmw_hit = s0_win0 || s0_win1;
    assign s1_dmw_hit = s1_win0 || s1_win1;
    assign s0_win     = s0_win0 ? dmw0 : dmw1;  // DMW0 wins when both match
    assign s1_win     = s1_win0 ? dmw0 : dmw1;

    // Physical segment replaces the virtual one, low 29 bits pass through
    assign s0_dmw_paddr = s0_dmw_hit ? {s0_win[27:25], s0_addr[28:0]} : '0;
    assign s1_dmw_paddr = s1_dmw_hit ? {s1_win[27:25], s1_addr[28:0]} : '0;
    assign s0_dmw_mat   = s0_dmw_hit ? s0_win[5:4] : '0;
    assign s1_dmw_mat   = s1_dmw_hit ? s1_win[5:4] : '0;

endmodule

/* source/tlb_hit_select.sv */
`timescale 1ns/1ps

module tlb_hit_select #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic [TLB_ENTRIES-1:0]                s0_hit_vec,
    input  logic [TLB_ENTRIES-1:0]                s1_hit_vec,
    input  logic [TLB_ENTRIES*mmu_pkg::PFN_W-1:0] pfn_bus,
    input  logic [TLB_ENTRIES*mmu_pkg::MAT_W-1:0] mat_bus,
    input  logic [TLB_ENTRIES-1:0]                huge_bus,
    output logic                                  s0_tlb_hit,
    output logic                                  s1_tlb_hit,
    output logic [mmu_pkg::PFN_W-1:0]             s0_pfn,
    output logic [mmu_pkg::PFN_W-1:0]             s1_pfn,
    output mmu_pkg::page_size_e                   s0_ps,
    output mmu_pkg::page_size_e                   s1_ps,
    output logic [mmu_pkg::MAT_W-1:0]             s0_tlb_mat,
    output logic [mmu_pkg::MAT_W-1:0]             s1_tlb_mat
);
    import mmu_pkg::*;

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    logic [IDX_W-1:0] s0_idx;
    logic [IDX_W-1:0] s1_idx;

    // Scans downward so the lowest hitting index is the one left standing
    function automatic logic [IDX_W-1:0] first_hit(input logic [TLB_ENTRIES-1:0] vec);
        logic [IDX_W-1:0] idx;
        idx = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = IDX_W'(i);
            end
        end
        return idx;
    endfunction

    assign s0_idx     = first_hit(s0_hit_vec);
    assign s1_idx     = first_hit(s1_hit_vec);
    assign s0_tlb_hit = |s0_hit_vec;
    assign s1_tlb_hit = |s1_hit_vec;

    assign s0_pfn     = s0_tlb_hit ? pfn_bus[s0_idx*PFN_W +: PFN_W] : '0;
    assign s1_pfn     = s1_tlb_hit ? pfn_bus[s1_idx*PFN_W +: PFN_W] : '0;
    assign s0_tlb_mat = s0_tlb_hit ? mat_bus[s0_idx*MAT_W +: MAT_W] : '0;
    assign s1_tlb_mat = s1_tlb_hit ? mat_bus[s1_idx*MAT_W +: MAT_W] : '0;

    assign s0_ps = !s0_tlb_hit ? page_size_e'(6'd0) : (huge_bus[s0_idx] ? PS_4M : PS_4K);
    assign s1_ps = !s1_tlb_hit ? page_size_e'(6'd0) : (huge_bus[s1_idx] ? PS_4M : PS_4K);

endmodule

/* source/tlb_entry.sv */
`timescale 1ns/1ps

module tlb_entry (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       we,
    input  logic [mmu_pkg::VPN_W-1:0]  vpn_in,
    input  logic [mmu_pkg::ASID_W-1:0] asid_in,
    input  logic [mmu_pkg::PFN_W-1:0]  pfn_in,
    input  logic [mmu_pkg::MAT_W-1:0]  mat_in,
    input  logic                       g_in,
    input  logic                       huge_in,
    input  logic                       v_in,
    input  logic [mmu_pkg::ASID_W-1:0] cur_asid,
    input  logic [31:0]                s0_addr,
    input  logic [31:0]                s1_addr,
    output logic                       s0_hit,
    output logic                       s1_hit,
    output logic [mmu_pkg::PFN_W-1:0]  pfn,
    output logic [mmu_pkg::MAT_W-1:0]  mat,
    output logic                       huge
);
    import mmu_pkg::*;

    logic [VPN_W-1:0]  vpn;
    logic [ASID_W-1:0] asid;
    logic              g;
    logic              v;
    logic              tag_ok;

    // A 4 MiB page compares only the upper ten bits of the page number
    function automatic logic page_match(input logic [31:0] addr, input logic [VPN_W-1:0] tag,
                                        input logic big);
        if (big) begin
            return addr[31:22] == tag[VPN_W-1:10];
        end
        return addr[31:12] == tag;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            v <= 1'b0;
        end else if (we) begin
            v <= v_in;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            vpn  <= vpn_in;
            asid <= asid_in;
            pfn  <= pfn_in;
            mat  <= mat_in;
            g    <= g_in;
            huge <= huge_in;
        end
    end

    assign tag_ok = v && (g || (asid == cur_asid));  // Global pages ignore the ASID
    assign s0_hit = tag_ok && page_match(s0_addr, vpn, huge);
    assign s1_hit = tag_ok && page_match(s1_addr, vpn, huge);

endmodule

/* source/tlb_csr_wb.sv */
`timescale 1ns/1ps

module tlb_csr_wb #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  logic [4:0]                 wb_adr,
    input  logic [31:0]                wb_dat_w,
    output logic [31:0]                wb_dat_r,
    output logic                       wb_ack,
    output mmu_pkg::xlate_mode_e       mode,
    output logic [mmu_pkg::ASID_W-1:0] cur_asid,
    output logic [31:0]                dmw0,
    output logic [31:0]                dmw1,
    output logic [TLB_ENTRIES-1:0]     ent_we_vec,
    output logic [mmu_pkg::VPN_W-1:0]  ent_vpn,
    output logic [mmu_pkg::ASID_W-1:0] ent_asid,
    output logic [mmu_pkg::PFN_W-1:0]  ent_pfn,
    output logic [mmu_pkg::MAT_W-1:0]  ent_mat,
    output logic                       ent_g,
    output logic                       ent_huge,
    output logic                       ent_v
);
    import mmu_pkg::*;

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    logic [31:0]      tlbhi;
    logic [31:0]      tlblo;
    logic [IDX_W-1:0] tlbidx;
    logic [IDX_W-1:0] wr_idx;
    logic             bus_req;
    logic             idx_wr;
    csr_addr_e        reg_sel;

    assign bus_req = wb_cyc && wb_stb && !wb_ack;  // One access per strobe
    assign reg_sel = csr_addr_e'(wb_adr);
    assign idx_wr  = bus_req && wb_we && (reg_sel == CSR_TLBIDX);
    assign wr_idx  = IDX_W'(32'(wb_dat_w[4:0]) % TLB_ENTRIES);

    // The staged entry lands in the TLB on the same edge that raises ack
    always_comb begin
        ent_we_vec = '0;
        if (idx_wr) begin
            ent_we_vec[wr_idx] = 1'b1;
        end
    end

    // ************************************************************************
    // Register file
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            mode     <= xlate_mode_e'(2'd0);
            cur_asid <= '0;
            dmw0     <= '0;  // Enable bit low, windows off
            dmw1     <= '0;
            tlbhi    <= '0;
            tlblo    <= '0;
            tlbidx   <= '0;
        end else begin
            wb_ack <= bus_req;
            if (bus_req && wb_we) begin
                case (reg_sel)
                    CSR_MODE:   mode     <= xlate_mode_e'(wb_dat_w[1:0]);
                    CSR_ASID:   cur_asid <= wb_dat_w[ASID_W-1:0];
                    CSR_DMW0:   dmw0     <= wb_dat_w;
                    CSR_DMW1:   dmw1     <= wb_dat_w;
                    CSR_TLBHI:  tlbhi    <= wb_dat_w;
                    CSR_TLBLO:  tlblo    <= wb_dat_w;
                    CSR_TLBIDX: tlbidx   <= wr_idx;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus_req) begin
            case (reg_sel)
                CSR_MODE:   wb_dat_r <= 32'(mode);
                CSR_ASID:   wb_dat_r <= 32'(cur_asid);
                CSR_DMW0:   wb_dat_r <= dmw0;
                CSR_DMW1:   wb_dat_r <= dmw1;
                CSR_TLBHI:  wb_dat_r <= tlbhi;
                CSR_TLBLO:  wb_dat_r <= tlblo;
                CSR_TLBIDX: wb_dat_r <= 32'(tlbidx);
                default:    wb_dat_r <= '0;
            endcase
        end
    end

    assign ent_vpn  = tlbhi[31:12];
    assign ent_asid = tlbhi[ASID_W-1:0];
    assign ent_pfn  = tlblo[31:12];
    assign ent_g    = tlblo[6];
    assign ent_mat  = tlblo[5:4];
    assign ent_huge = tlblo[1];  // Set for a 4 MiB page
    assign ent_v    = tlblo[0];

endmodule

/* source/mmu_pkg.sv */
package mmu_pkg;

    localparam int VPN_W  = 20;  // Virtual page number of a 4 KiB page
    localparam int PFN_W  = 20;
    localparam int ASID_W = 10;
    localparam int MAT_W  = 2;

    // Values 0 and 3 select no translation and give zero outputs
    typedef enum logic [1:0] {
        MODE_DIRECT = 2'd1,
        MODE_MAP    = 2'd2
    } xlate_mode_e;

    // Page shift of a TLB entry
    typedef enum logic [5:0] {
        PS_4K = 6'd12,
        PS_4M = 6'd22
    } page_size_e;

    // Byte offsets of the Wishbone registers
    typedef enum logic [4:0] {
        CSR_MODE   = 5'h00,
        CSR_ASID   = 5'h04,
        CSR_DMW0   = 5'h08,
        CSR_DMW1   = 5'h0C,
        CSR_TLBHI  = 5'h10,
        CSR_TLBLO  = 5'h14,
        CSR_TLBIDX = 5'h18
    } csr_addr_e;

endpackage
